// ==== src/gpu_defines.svh ====
// Front end configuration macros
// Warp count, PC width, opcode encodings and memory sizes

`ifndef GPU_DEFINES_SVH
`define GPU_DEFINES_SVH

// Machine size
`define NUM_WARPS 4
`define PC_W 32

// Instruction memory depth in 32-bit words
`define IMEM_DEPTH 1024

// Depth of the fetch queue and of the instruction buffer
`define FIFO_DEPTH 2

// ============================================================
// RV32I style major opcodes
// ============================================================
`define OPCODE_LUI    7'b0110111
`define OPCODE_AUIPC  7'b0010111
`define OPCODE_JAL    7'b1101111
`define OPCODE_JALR   7'b1100111
`define OPCODE_BRANCH 7'b1100011
`define OPCODE_LOAD   7'b0000011
`define OPCODE_STORE  7'b0100011
`define OPCODE_OP_IMM 7'b0010011
`define OPCODE_OP     7'b0110011
// An all-zero word decodes as a no-op
`define OPCODE_NOP    7'b0000000

`endif

// ==== src/gpu_pkg.sv ====
// Shared front end types
// Warp index, raw fetch record and decoded instruction record

`default_nettype none

`include "gpu_defines.svh"

package gpu_pkg;

  // Warp index
  typedef logic [$clog2(`NUM_WARPS)-1:0] warp_id_t;

  // Record produced by fetch
  typedef struct packed {
    logic [`PC_W-1:0] pc;
    warp_id_t         warp;
    logic [31:0]      word;
  } inst_raw_t;

  // Record handed to the instruction buffer
  typedef struct packed {
    logic [`PC_W-1:0] pc;
    warp_id_t         warp;
    logic [6:0]       opcode;
    logic [2:0]       funct3;
    logic [4:0]       rd;
    logic [4:0]       rs1;
    logic [4:0]       rs2;
    logic [31:0]      imm;
    // Opcode not recognized, warp is parked
    logic             illegal;
  } inst_decoded_t;

endpackage

`default_nettype wire

// ==== src/warp_pc_table.sv ====
// Per-warp PC table
// Stall and halt state, round-robin ready warp selection,
// split updates from decode and external resume writes

`timescale 1ns/1ps
`default_nettype none

`include "gpu_defines.svh"

module warp_pc_table import gpu_pkg::*; (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  take,
  input  warp_id_t              take_warp,
  output logic                  sel_valid,
  output warp_id_t              sel_warp,
  output logic [`PC_W-1:0]      sel_pc,
  input  logic                  split_valid,
  input  warp_id_t              split_warp,
  input  logic [`PC_W-1:0]      split_pc,
  input  logic                  split_stall,
  input  logic                  resume_valid,
  input  warp_id_t              resume_warp,
  input  logic [`PC_W-1:0]      resume_pc,
  output logic [`NUM_WARPS-1:0] halted
);

  logic [`PC_W-1:0]      pc_q [`NUM_WARPS];
  // Set while in flight or parked
  logic [`NUM_WARPS-1:0] stall_q;
  // Set only while parked waiting for resume
  logic [`NUM_WARPS-1:0] halt_q;
  warp_id_t              last_q;

  // ============================================================
  // Round-robin pick, starting after the last warp taken
  // ============================================================
  always_comb begin
    int idx;
    sel_valid = 1'b0;
    sel_warp  = '0;
    // Walk from farthest to nearest so the nearest ready warp wins
    for (int i = `NUM_WARPS; i >= 1; i--) begin
      idx = (int'(last_q) + i) % `NUM_WARPS;
      if (!stall_q[idx]) begin
        sel_valid = 1'b1;
        sel_warp  = warp_id_t'(idx);
      end
    end
  end

  assign sel_pc = pc_q[sel_warp];
  assign halted = halt_q;

  // ============================================================
  // State updates
  // ============================================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      stall_q <= '0;
      halt_q  <= '0;
      last_q  <= '0;
      for (int w = 0; w < `NUM_WARPS; w++) begin
        pc_q[w] <= `PC_W'(w * 256);
      end
    end else begin
      if (take) begin
        last_q <= take_warp;
      end
      for (int w = 0; w < `NUM_WARPS; w++) begin
        if (take && take_warp == warp_id_t'(w)) begin
          stall_q[w] <= 1'b1;
        end
        // Resume only wakes a parked warp
        if (resume_valid && resume_warp == warp_id_t'(w) && halt_q[w]) begin
          pc_q[w]    <= resume_pc;
          stall_q[w] <= 1'b0;
          halt_q[w]  <= 1'b0;
        end
        // Split update wins over a resume to the same warp
        if (split_valid && split_warp == warp_id_t'(w)) begin
          pc_q[w]    <= split_pc;
          stall_q[w] <= split_stall;
          halt_q[w]  <= split_stall;
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== src/inst_fetch.sv ====
// Instruction fetch
// Reads instruction memory for the selected warp and
// holds the returned word as a pending raw record

`timescale 1ns/1ps
`default_nettype none

`include "gpu_defines.svh"

module inst_fetch import gpu_pkg::*; (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             sel_valid,
  input  warp_id_t         sel_warp,
  input  logic [`PC_W-1:0] sel_pc,
  output logic             take,
  output warp_id_t         take_warp,
  output logic             imem_en,
  output logic [`PC_W-1:0] imem_addr,
  input  logic [31:0]      imem_data,
  output logic             raw_valid,
  input  logic             raw_ready,
  output inst_raw_t        raw
);

  // Goes high one cycle after reset release
  logic             run_q;
  logic             pend_q;
  // Memory word arrives this cycle and is not yet latched
  logic             fresh_q;
  logic [`PC_W-1:0] pc_q;
  warp_id_t         warp_q;
  logic [31:0]      word_q;

  // One read at a time, only with no record outstanding
  assign take      = run_q && sel_valid && !pend_q;
  assign take_warp = sel_warp;
  assign imem_en   = take;
  assign imem_addr = sel_pc;

  assign raw_valid = pend_q;
  assign raw.pc    = pc_q;
  assign raw.warp  = warp_q;
  // Bypass the memory output on the first cycle, then use the held copy
  assign raw.word  = fresh_q ? imem_data : word_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      run_q   <= 1'b0;
      pend_q  <= 1'b0;
      fresh_q <= 1'b0;
    end else begin
      run_q <= 1'b1;
      if (take) begin
        pend_q  <= 1'b1;
        fresh_q <= 1'b1;
      end else begin
        fresh_q <= 1'b0;
        if (raw_valid && raw_ready) begin
          pend_q <= 1'b0;
        end
      end
    end
  end

  // Record payload
  always_ff @(posedge clk) begin
    if (take) begin
      pc_q   <= sel_pc;
      warp_q <= sel_warp;
    end else if (fresh_q) begin
      word_q <= imem_data;
    end
  end

endmodule

`default_nettype wire

// ==== src/inst_fifo.sv ====
// Valid/ready FIFO with a configurable payload type
// Circular buffer with count-based full and empty

`timescale 1ns/1ps
`default_nettype none

`include "gpu_defines.svh"

module inst_fifo import gpu_pkg::*; #(
  parameter type payload_t = inst_raw_t,
  parameter int  DEPTH     = `FIFO_DEPTH
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     in_valid,
  output logic     in_ready,
  input  payload_t in_data,
  output logic     out_valid,
  input  logic     out_ready,
  output payload_t out_data
);

  localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CW = $clog2(DEPTH + 1);

  payload_t mem [DEPTH];
  logic [PW-1:0] wr_ptr;
  logic [PW-1:0] rd_ptr;
  logic [CW-1:0] count;
  logic push;
  logic pop;

  assign in_ready  = (count != CW'(DEPTH));
  assign out_valid = (count != '0);
  assign out_data  = mem[rd_ptr];
  assign push      = in_valid && in_ready;
  assign pop       = out_valid && out_ready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == PW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= in_data;
    end
  end

endmodule

`default_nettype wire

// ==== src/inst_decode.sv ====
// Instruction decoder
// Three-state FSM, field and immediate extraction,
// next-PC split update toward the PC table

`timescale 1ns/1ps
`default_nettype none

`include "gpu_defines.svh"

module inst_decode import gpu_pkg::*; (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             din_valid,
  output logic             din_ready,
  input  inst_raw_t        din,
  output logic             dout_valid,
  input  logic             dout_ready,
  output inst_decoded_t    dout,
  output logic             split_valid,
  output warp_id_t         split_warp,
  output logic [`PC_W-1:0] split_pc,
  output logic             split_stall
);

  typedef enum logic [1:0] {
    IDLE,
    DECODE,
    UPDATE
  } state_t;

  state_t        state_q;
  inst_raw_t     raw_q;
  inst_decoded_t dec_d;
  inst_decoded_t dec_q;
  logic          is_jump;

  assign din_ready  = (state_q == IDLE);
  assign dout_valid = (state_q == UPDATE);
  assign dout       = dec_q;

  // ============================================================
  // FSM
  // ============================================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= IDLE;
    end else begin
      case (state_q)
        IDLE:    if (din_valid) state_q <= DECODE;
        DECODE:  state_q <= UPDATE;
        UPDATE:  if (dout_ready) state_q <= IDLE;
        default: state_q <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (din_valid && din_ready) begin
      raw_q <= din;
    end
    if (state_q == DECODE) begin
      dec_q <= dec_d;
    end
  end

  // ============================================================
  // Field extraction
  // ============================================================
  always_comb begin
    logic [31:0] w;
    w = raw_q.word;
    dec_d        = '0;
    dec_d.pc     = raw_q.pc;
    dec_d.warp   = raw_q.warp;
    dec_d.opcode = w[6:0];
    case (w[6:0])
      `OPCODE_LUI, `OPCODE_AUIPC: begin
        dec_d.rd  = w[11:7];
        dec_d.imm = {w[31:12], 12'b0};
      end
      `OPCODE_JAL: begin
        dec_d.rd  = w[11:7];
        dec_d.imm = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
      end
      // I-type formats share one layout
      `OPCODE_JALR, `OPCODE_LOAD, `OPCODE_OP_IMM: begin
        dec_d.funct3 = w[14:12];
        dec_d.rd     = w[11:7];
        dec_d.rs1    = w[19:15];
        dec_d.imm    = {{20{w[31]}}, w[31:20]};
      end
      `OPCODE_BRANCH: begin
        dec_d.funct3 = w[14:12];
        dec_d.rs1    = w[19:15];
        dec_d.rs2    = w[24:20];
        dec_d.imm    = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
      end
      `OPCODE_STORE: begin
        dec_d.funct3 = w[14:12];
        dec_d.rs1    = w[19:15];
        dec_d.rs2    = w[24:20];
        dec_d.imm    = {{20{w[31]}}, w[31:25], w[11:7]};
      end
      `OPCODE_OP: begin
        dec_d.funct3 = w[14:12];
        dec_d.rd     = w[11:7];
        dec_d.rs1    = w[19:15];
        dec_d.rs2    = w[24:20];
      end
      `OPCODE_NOP: begin
      end
      default: dec_d.illegal = 1'b1;
    endcase
  end

  // ============================================================
  // Split update, issued on the dout transfer
  // ============================================================
  // JALR target ignores rs1, there is no register file here
  assign is_jump = (dec_q.opcode == `OPCODE_JAL) || (dec_q.opcode == `OPCODE_JALR);

  assign split_valid = dout_valid && dout_ready;
  assign split_warp  = dec_q.warp;
  assign split_pc    = is_jump ? dec_q.pc + dec_q.imm : dec_q.pc + `PC_W'(4);
  // Branch outcome and AUIPC wait for an external resume
  assign split_stall = dec_q.illegal
                    || (dec_q.opcode == `OPCODE_BRANCH)
                    || (dec_q.opcode == `OPCODE_AUIPC);

endmodule

`default_nettype wire

// ==== src/gpu_frontend_top.sv ====
// SIMT core front end top level
// PC table, fetch, fetch queue, decoder and instruction buffer

`timescale 1ns/1ps
`default_nettype none

`include "gpu_defines.svh"

module gpu_frontend_top import gpu_pkg::*; (
  input  logic                  clk,
  input  logic                  rst_n,
  output logic                  imem_en,
  output logic [`PC_W-1:0]      imem_addr,
  input  logic [31:0]           imem_data,
  input  logic                  resume_valid,
  input  warp_id_t              resume_warp,
  input  logic [`PC_W-1:0]      resume_pc,
  output logic                  dout_valid,
  input  logic                  dout_ready,
  output inst_decoded_t         dout,
  output logic [`NUM_WARPS-1:0] halted
);

  logic             sel_valid;
  warp_id_t         sel_warp;
  logic [`PC_W-1:0] sel_pc;
  logic             take;
  warp_id_t         take_warp;
  logic             raw_valid;
  logic             raw_ready;
  inst_raw_t        raw;
  logic             fq_valid;
  logic             fq_ready;
  inst_raw_t        fq_data;
  logic             dec_valid;
  logic             dec_ready;
  inst_decoded_t    dec_data;
  logic             split_valid;
  warp_id_t         split_warp;
  logic [`PC_W-1:0] split_pc;
  logic             split_stall;

  warp_pc_table u_pc_table (
    .clk(clk), .rst_n(rst_n),
    .take(take), .take_warp(take_warp),
    .sel_valid(sel_valid), .sel_warp(sel_warp), .sel_pc(sel_pc),
    .split_valid(split_valid), .split_warp(split_warp),
    .split_pc(split_pc), .split_stall(split_stall),
    .resume_valid(resume_valid), .resume_warp(resume_warp), .resume_pc(resume_pc),
    .halted(halted)
  );

  inst_fetch u_fetch (
    .clk(clk), .rst_n(rst_n),
    .sel_valid(sel_valid), .sel_warp(sel_warp), .sel_pc(sel_pc),
    .take(take), .take_warp(take_warp),
    .imem_en(imem_en), .imem_addr(imem_addr), .imem_data(imem_data),
    .raw_valid(raw_valid), .raw_ready(raw_ready), .raw(raw)
  );

  inst_fifo #(.payload_t(inst_raw_t), .DEPTH(`FIFO_DEPTH)) fetch_q (
    .clk(clk), .rst_n(rst_n),
    .in_valid(raw_valid), .in_ready(raw_ready), .in_data(raw),
    .out_valid(fq_valid), .out_ready(fq_ready), .out_data(fq_data)
  );

  inst_decode u_decode (
    .clk(clk), .rst_n(rst_n),
    .din_valid(fq_valid), .din_ready(fq_ready), .din(fq_data),
    .dout_valid(dec_valid), .dout_ready(dec_ready), .dout(dec_data),
    .split_valid(split_valid), .split_warp(split_warp),
    .split_pc(split_pc), .split_stall(split_stall)
  );

  inst_fifo #(.payload_t(inst_decoded_t), .DEPTH(`FIFO_DEPTH)) ibuf_q (
    .clk(clk), .rst_n(rst_n),
    .in_valid(dec_valid), .in_ready(dec_ready), .in_data(dec_data),
    .out_valid(dout_valid), .out_ready(dout_ready), .out_data(dout)
  );

endmodule

`default_nettype wire

// ==== testbench/gpu_frontend_props.sv ====
// Concurrent checks on the front end top level
// Held output stability, split update into the buffer, fetch quiet in reset

`timescale 1ns/1ps
`default_nettype none

module gpu_frontend_props import gpu_pkg::*; (
  input logic          clk,
  input logic          rst_n,
  input logic          dout_valid,
  input logic          dout_ready,
  input inst_decoded_t dout,
  input logic          imem_en,
  input logic          split_valid
);

  // Output held under back-pressure
  a_dout_stable: assert property (@(posedge clk) disable iff (!rst_n)
    dout_valid && !dout_ready |=> dout_valid && $stable(dout))
    else $error("dout changed while waiting for dout_ready");

  // A PC table write always leaves a record in the instruction buffer
  a_split_on_transfer: assert property (@(posedge clk) disable iff (!rst_n)
    split_valid |=> dout_valid)
    else $error("split update without a record entering the instruction buffer");

  a_no_fetch_in_reset: assert property (@(posedge clk) !rst_n |-> !imem_en)
    else $error("instruction memory enabled during reset");

endmodule

bind gpu_frontend_top gpu_frontend_props u_props (
  .clk(clk), .rst_n(rst_n),
  .dout_valid(dout_valid), .dout_ready(dout_ready), .dout(dout),
  .imem_en(imem_en),
  .split_valid(split_valid)
);

`default_nettype wire

// ==== testbench/tb_gpu_frontend.sv ====
// Testbench for the SIMT front end
// Clock, reset, instruction memory model, reference decoder,
// directed test tasks and the closing report

`timescale 1ns/1ps
`default_nettype none

`include "gpu_defines.svh"

module tb_gpu_frontend import gpu_pkg::*; ();

  typedef logic [31:0] pc_list_t[$];

  localparam int AW = $clog2(`IMEM_DEPTH);
  // Budget of about 1000 cycles for each of the six tests
  localparam int MAX_CYCLES = 6 * 1000;

  logic                  clk;
  logic                  rst_n;
  logic                  imem_en;
  logic [`PC_W-1:0]      imem_addr;
  logic [31:0]           imem_data;
  logic                  resume_valid;
  warp_id_t              resume_warp;
  logic [`PC_W-1:0]      resume_pc;
  logic                  dout_valid;
  logic                  dout_ready;
  inst_decoded_t         dout;
  logic [`NUM_WARPS-1:0] halted;

  logic [31:0]   mem [`IMEM_DEPTH];
  inst_decoded_t got_q[$];
  integer        seed;
  int            cycles;
  int            reads;
  int            errors;
  int            test_errors;
  int            tests_run;
  int            tests_failed;
  string         cur_test;

  gpu_frontend_top dut (
    .clk(clk), .rst_n(rst_n),
    .imem_en(imem_en), .imem_addr(imem_addr), .imem_data(imem_data),
    .resume_valid(resume_valid), .resume_warp(resume_warp), .resume_pc(resume_pc),
    .dout_valid(dout_valid), .dout_ready(dout_ready), .dout(dout),
    .halted(halted)
  );

  always #5 clk = ~clk;

  // Synchronous read with the word valid one cycle after the enable
  always @(posedge clk) begin
    if (imem_en) begin
      imem_data <= mem[imem_addr[AW+1:2]];
      reads++;
    end
  end

  // Every instruction buffer transfer in arrival order
  always @(posedge clk) begin
    if (rst_n && dout_valid && dout_ready) begin
      got_q.push_back(dout);
    end
  end

  // ============================================================
  // Instruction encoders and reference decoder
  // ============================================================
  function automatic logic [31:0] r_type(logic [4:0] rd, logic [4:0] rs1, logic [4:0] rs2,
                                         logic [2:0] f3);
    return {7'b0100000, rs2, rs1, f3, rd, `OPCODE_OP};
  endfunction

  function automatic logic [31:0] i_type(logic [6:0] op, logic [4:0] rd, logic [4:0] rs1,
                                         logic [11:0] imm);
    return {imm, rs1, 3'b010, rd, op};
  endfunction

  function automatic logic [31:0] s_type(logic [4:0] rs1, logic [4:0] rs2, logic [11:0] imm);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], `OPCODE_STORE};
  endfunction

  function automatic logic [31:0] u_type(logic [6:0] op, logic [4:0] rd, logic [19:0] imm);
    return {imm, rd, op};
  endfunction

  function automatic logic [31:0] j_type(logic [4:0] rd, logic [20:0] imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, `OPCODE_JAL};
  endfunction

  function automatic logic [31:0] b_type(logic [4:0] rs1, logic [4:0] rs2, logic [12:0] imm);
    return {imm[12], imm[10:5], rs2, rs1, 3'b001, imm[4:1], imm[11], `OPCODE_BRANCH};
  endfunction

  // Background word is a branch whose register fields carry the word address
  function automatic logic [31:0] fill_word(int idx);
    logic [9:0] a;
    a = 10'(idx);
    return {7'b0, a[4:0], a[9:5], 3'b000, 5'b0, `OPCODE_BRANCH};
  endfunction

  function automatic inst_decoded_t ref_decode(logic [31:0] pc, warp_id_t w, logic [31:0] word);
    inst_decoded_t d;
    logic [6:0]    op;
    op       = word[6:0];
    d        = '0;
    d.pc     = pc;
    d.warp   = w;
    d.opcode = op;
    case (op)
      `OPCODE_LUI, `OPCODE_AUIPC: begin
        d.rd  = word[11:7];
        d.imm = {word[31:12], 12'h000};
      end
      `OPCODE_JAL: begin
        d.rd  = word[11:7];
        d.imm = 32'($signed({word[31], word[19:12], word[20], word[30:21], 1'b0}));
      end
      `OPCODE_JALR, `OPCODE_LOAD, `OPCODE_OP_IMM: begin
        d.funct3 = word[14:12];
        d.rd     = word[11:7];
        d.rs1    = word[19:15];
        d.imm    = 32'($signed(word[31:20]));
      end
      `OPCODE_STORE: begin
        d.funct3 = word[14:12];
        d.rs1    = word[19:15];
        d.rs2    = word[24:20];
        d.imm    = 32'($signed({word[31:25], word[11:7]}));
      end
      `OPCODE_BRANCH: begin
        d.funct3 = word[14:12];
        d.rs1    = word[19:15];
        d.rs2    = word[24:20];
        d.imm    = 32'($signed({word[31], word[7], word[30:25], word[11:8], 1'b0}));
      end
      `OPCODE_OP: begin
        d.funct3 = word[14:12];
        d.rd     = word[11:7];
        d.rs1    = word[19:15];
        d.rs2    = word[24:20];
      end
      `OPCODE_NOP: ;
      default: d.illegal = 1'b1;
    endcase
    return d;
  endfunction

  // ============================================================
  // Helpers
  // ============================================================
  function automatic logic [31:0] base_pc(int w);
    return 32'(w * 256);
  endfunction

  function automatic int outputs_of(warp_id_t w);
    int n;
    n = 0;
    foreach (got_q[i]) begin
      if (got_q[i].warp == w) n++;
    end
    return n;
  endfunction

  function automatic int find_output(warp_id_t w, int k);
    int seen;
    seen = 0;
    foreach (got_q[i]) begin
      if (got_q[i].warp == w) begin
        if (seen == k) return i;
        seen++;
      end
    end
    return -1;
  endfunction

  task automatic count_error();
    errors++;
    test_errors++;
  endtask

  task automatic put_word(logic [31:0] pc, logic [31:0] word);
    mem[pc[AW+1:2]] = word;
  endtask

  task automatic begin_test(string name);
    @(posedge clk);
    rst_n        <= 1'b0;
    resume_valid <= 1'b0;
    dout_ready   <= 1'b1;
    cur_test    = name;
    test_errors = 0;
    for (int i = 0; i < `IMEM_DEPTH; i++) begin
      mem[i] = fill_word(i);
    end
  endtask

  task automatic release_reset();
    repeat (16) @(posedge clk);
    got_q.delete();
    reads = 0;
    rst_n <= 1'b1;
  endtask

  task automatic finish_test();
    // Drain until every warp is parked and the instruction buffer is empty
    while (halted != '1 || dout_valid) @(negedge clk);
    // One memory read for each record delivered
    check_field("memory reads", got_q.size(), reads);
    tests_run++;
    if (test_errors == 0) begin
      $display("test %s: ok", cur_test);
    end else begin
      tests_failed++;
      $display("test %s: %0d errors", cur_test, test_errors);
    end
  endtask

  task automatic wait_outputs(warp_id_t w, int n);
    while (outputs_of(w) < n) @(negedge clk);
  endtask

  task automatic wake_warp(warp_id_t w, logic [31:0] pc);
    @(posedge clk);
    resume_valid <= 1'b1;
    resume_warp  <= w;
    resume_pc    <= pc;
    @(posedge clk);
    resume_valid <= 1'b0;
  endtask

  task automatic check_field(string what, logic [31:0] want, logic [31:0] got);
    if (want !== got) begin
      $display("CHECK FAILED %s %s: expected %h, actual %h", cur_test, what, want, got);
      count_error();
    end
  endtask

  task automatic check_entry(inst_decoded_t got, logic [31:0] pc, warp_id_t w);
    inst_decoded_t want;
    want = ref_decode(pc, w, mem[pc[AW+1:2]]);
    if (got !== want) begin
      $display("CHECK FAILED %s decoded record: expected %h, actual %h", cur_test, want, got);
      count_error();
    end
  endtask

  // Output count and pc order of one warp with each record against the reference
  task automatic check_program(warp_id_t w, pc_list_t pcs);
    int idx;
    check_field($sformatf("warp %0d output count", w), pcs.size(), outputs_of(w));
    foreach (pcs[k]) begin
      idx = find_output(w, k);
      if (idx >= 0) check_entry(got_q[idx], pcs[k], w);
    end
  endtask

  task automatic check_imm(warp_id_t w, int k, logic [31:0] want);
    int idx;
    idx = find_output(w, k);
    if (idx < 0) begin
      $display("Output %0d of warp %0d never arrived in test %s", k, w, cur_test);
      count_error();
    end else begin
      check_field($sformatf("warp %0d output %0d imm", w, k), want, got_q[idx].imm);
    end
  endtask

  // ============================================================
  // Directed tests
  // ============================================================
  task automatic test_straight_line();
    pc_list_t pcs;
    begin_test("straight_line");
    for (int k = 0; k < 8; k++) begin
      if (k % 2 == 0) put_word(4 * k, r_type(5'(k + 1), 5'(k + 2), 5'(k + 3), 3'(k)));
      else put_word(4 * k, i_type(`OPCODE_OP_IMM, 5'(k + 1), 5'(k), 12'(k * 100 - 300)));
    end
    release_reset();
    // Word 8 is background and parks warp 0
    for (int w = 0; w < `NUM_WARPS; w++) wait_outputs(warp_id_t'(w), (w == 0) ? 9 : 1);
    pcs = {};
    for (int k = 0; k < 9; k++) pcs.push_back(32'(4 * k));
    check_program(2'd0, pcs);
    for (int w = 1; w < `NUM_WARPS; w++) wake_warp(warp_id_t'(w), base_pc(w) + 32'h40);
    for (int w = 1; w < `NUM_WARPS; w++) begin
      wait_outputs(warp_id_t'(w), 2);
      pcs = {base_pc(w), base_pc(w) + 32'h40};
      check_program(warp_id_t'(w), pcs);
    end
    finish_test();
  endtask

  task automatic test_imm_formats();
    pc_list_t pcs;
    begin_test("imm_formats");
    put_word(32'h000, u_type(`OPCODE_LUI, 5'd1, 20'hFFFFF));
    put_word(32'h004, i_type(`OPCODE_LOAD, 5'd2, 5'd3, 12'hFF8));
    put_word(32'h008, s_type(5'd4, 5'd5, 12'h123));
    put_word(32'h00C, i_type(`OPCODE_JALR, 5'd6, 5'd7, 12'h008));
    put_word(32'h100, u_type(`OPCODE_AUIPC, 5'd9, 20'h00012));
    put_word(32'h200, s_type(5'd10, 5'd11, 12'h801));
    release_reset();
    wait_outputs(2'd0, 5);
    wait_outputs(2'd1, 1);
    wait_outputs(2'd2, 2);
    wait_outputs(2'd3, 1);
    pcs = {32'h000, 32'h004, 32'h008, 32'h00C, 32'h014};
    check_program(2'd0, pcs);
    pcs = {32'h100};
    check_program(2'd1, pcs);
    pcs = {32'h200, 32'h204};
    check_program(2'd2, pcs);
    check_imm(2'd0, 0, 32'hFFFF_F000);
    check_imm(2'd0, 1, 32'hFFFF_FFF8);
    check_imm(2'd0, 2, 32'h0000_0123);
    check_imm(2'd0, 3, 32'h0000_0008);
    check_imm(2'd1, 0, 32'h0001_2000);
    check_imm(2'd2, 0, 32'hFFFF_F801);
    finish_test();
  endtask

  task automatic test_redirect();
    pc_list_t pcs;
    begin_test("redirect");
    put_word(32'h000, j_type(5'd1, 21'd16));
    put_word(32'h010, i_type(`OPCODE_JALR, 5'd2, 5'd3, 12'hFF4));
    put_word(32'h004, i_type(`OPCODE_OP_IMM, 5'd4, 5'd5, 12'h010));
    put_word(32'h100, r_type(5'd6, 5'd7, 5'd8, 3'd0));
    put_word(32'h104, j_type(5'd1, 21'h1F_FFF8));
    release_reset();
    wait_outputs(2'd0, 4);
    wait_outputs(2'd1, 3);
    pcs = {32'h000, 32'h010, 32'h004, 32'h008};
    check_program(2'd0, pcs);
    // Backward jump lands on the last word of warp 0
    pcs = {32'h100, 32'h104, 32'h0FC};
    check_program(2'd1, pcs);
    check_imm(2'd0, 0, 32'h0000_0010);
    check_imm(2'd0, 1, 32'hFFFF_FFF4);
    check_imm(2'd1, 1, 32'hFFFF_FFF8);
    finish_test();
  endtask

  task automatic test_stall_resume();
    pc_list_t pcs;
    begin_test("stall_resume");
    put_word(32'h000, i_type(`OPCODE_OP_IMM, 5'd1, 5'd0, 12'h005));
    put_word(32'h004, b_type(5'd1, 5'd2, 13'h0010));
    put_word(32'h040, r_type(5'd3, 5'd1, 5'd2, 3'd4));
    put_word(32'h044, u_type(`OPCODE_AUIPC, 5'd4, 20'h00100));
    put_word(32'h080, i_type(`OPCODE_OP_IMM, 5'd5, 5'd4, 12'h7FF));
    release_reset();
    wait_outputs(2'd0, 2);
    repeat (20) @(negedge clk);
    check_field("outputs while parked on branch", 2, outputs_of(2'd0));
    check_field("halted after branch", 1, halted[0]);
    wake_warp(2'd0, 32'h040);
    wait_outputs(2'd0, 4);
    repeat (20) @(negedge clk);
    check_field("outputs while parked on auipc", 4, outputs_of(2'd0));
    check_field("halted after auipc", 1, halted[0]);
    wake_warp(2'd0, 32'h080);
    wait_outputs(2'd0, 6);
    pcs = {32'h000, 32'h004, 32'h040, 32'h044, 32'h080, 32'h084};
    check_program(2'd0, pcs);
    finish_test();
  endtask

  task automatic test_multi_warp();
    pc_list_t pcs;
    logic [31:0] r;
    begin_test("multi_warp");
    for (int w = 0; w < `NUM_WARPS; w++) begin
      for (int k = 0; k < 10; k++) begin
        r = $random(seed);
        put_word(base_pc(w) + 32'(4 * k), {r[31:7], r[0] ? `OPCODE_OP : `OPCODE_OP_IMM});
      end
    end
    release_reset();
    // Random back-pressure on the instruction buffer
    while (got_q.size() < 4 * 11) begin
      @(posedge clk);
      dout_ready <= 1'($random(seed));
    end
    @(posedge clk);
    dout_ready <= 1'b1;
    repeat (20) @(negedge clk);
    check_field("total outputs", 4 * 11, got_q.size());
    for (int w = 0; w < `NUM_WARPS; w++) begin
      pcs = {};
      for (int k = 0; k < 11; k++) pcs.push_back(base_pc(w) + 32'(4 * k));
      check_program(warp_id_t'(w), pcs);
    end
    finish_test();
  endtask

  task automatic test_illegal();
    pc_list_t pcs;
    int idx;
    begin_test("illegal_opcode");
    put_word(32'h200, r_type(5'd1, 5'd2, 5'd3, 3'd1));
    put_word(32'h204, 32'h0123_45FF);
    for (int w = 0; w < `NUM_WARPS; w++) begin
      if (w != 2) begin
        for (int k = 0; k < 4; k++) begin
          put_word(base_pc(w) + 32'(4 * k), r_type(5'(k), 5'(w), 5'd9, 3'd0));
        end
      end
    end
    release_reset();
    for (int w = 0; w < `NUM_WARPS; w++) wait_outputs(warp_id_t'(w), (w == 2) ? 2 : 5);
    pcs = {32'h200, 32'h204};
    check_program(2'd2, pcs);
    idx = find_output(2'd2, 1);
    if (idx >= 0) check_field("illegal flag", 1, got_q[idx].illegal);
    check_field("halted bit of warp 2", 1, halted[2]);
    for (int w = 0; w < `NUM_WARPS; w++) begin
      if (w != 2) begin
        pcs = {};
        for (int k = 0; k < 5; k++) pcs.push_back(base_pc(w) + 32'(4 * k));
        check_program(warp_id_t'(w), pcs);
      end
    end
    finish_test();
  endtask

  // ============================================================
  // Run control
  // ============================================================
  initial begin
    cycles = 0;
    while (cycles < MAX_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout after %0d cycles in test %s", cycles, cur_test);
    $display("sim failed");
    $finish;
  end

  initial begin
    clk          = 1'b0;
    rst_n        = 1'b0;
    imem_data    = '0;
    resume_valid = 1'b0;
    resume_warp  = '0;
    resume_pc    = '0;
    dout_ready   = 1'b0;
    seed         = 32'h89d5_408b;
    reads        = 0;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    cur_test     = "startup";
    test_straight_line();
    test_imm_formats();
    test_redirect();
    test_stall_resume();
    test_multi_warp();
    test_illegal();
    $display("tests run %0d, tests failed %0d, check errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+src
src/gpu_pkg.sv
src/warp_pc_table.sv
src/inst_fetch.sv
src/inst_fifo.sv
src/inst_decode.sv
src/gpu_frontend_top.sv
testbench/gpu_frontend_props.sv
testbench/tb_gpu_frontend.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the front end testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f files.f \
  --top-module tb_gpu_frontend -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/Vtb_gpu_frontend)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "sim passed"; then
  exit 0
fi
exit 1
